// File: Bender.yml
package:
  name: divsqrt

export_include_dirs:
  - include

sources:
  # Synthesizable RTL in compile order
  - files:
      - verilog/divsqrt_pkg.sv
      - verilog/divsqrt_pipe_regs.sv
      - verilog/divsqrt_iter_core.sv
      - verilog/divsqrt_ctrl.sv
      - verilog/divsqrt_top.sv

  # Self-checking testbench
  - target: test
    files:
      - sim/tb_divsqrt.sv

// File: include/divsqrt_macros.svh
// Sizing parameters of the divide/sqrt unit, included by the package and the RTL modules
`ifndef DIVSQRT_MACROS_SVH
`define DIVSQRT_MACROS_SVH

// --------------------------------------------------
// Datapath sizes
// --------------------------------------------------
// Operand and result width in bits
// Must be even, the square root runs on bit pairs
`define DIVSQRT_WIDTH 32

// Width of the request tag that returns with the result
`define DIVSQRT_TAG_WIDTH 4

// --------------------------------------------------
// Pipeline depth
// --------------------------------------------------
// Register stages in front of the control FSM
// Zero turns the input pipeline into plain wires
`define DIVSQRT_NUM_INP_REGS 1

// Register stages behind the control FSM
`define DIVSQRT_NUM_OUT_REGS 1

`endif

// File: sim/tb_divsqrt.sv
// Self-checking testbench for the divide/sqrt unit, run as top module tb_divsqrt with the RTL
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_macros.svh"

module tb_divsqrt;
  import divsqrt_pkg::*;

  localparam int W         = `DIVSQRT_WIDTH;
  localparam int N_DIV     = 24;
  localparam int N_SQRT    = 24;
  localparam int N_DZ      = 4;
  localparam int N_BP      = 48;
  // Two latency probes and three flush requests on top
  localparam int TOTAL_OPS = 2 + N_DIV + N_SQRT + N_DZ + N_BP + 3;
  localparam int LIMIT     = TOTAL_OPS * (W + 10) + 500;

  logic          clk;
  logic          rst_n;
  logic          flush;
  logic          in_valid;
  logic          in_ready;
  divsqrt_req_t  req;
  logic          out_valid;
  logic          out_ready;
  divsqrt_resp_t resp;
  logic          busy;

  // Scoreboard state
  divsqrt_resp_t                 exp_q[$];
  logic [31:0]                   lfsr_q = 32'h53920103;
  logic [`DIVSQRT_TAG_WIDTH-1:0] tag_cnt = '0;
  logic                          stall_en = 1'b0;
  int                            cycle_cnt = 0;
  int                            accept_cycle = 0;
  int                            last_out_cycle = 0;
  int                            n_in = 0;
  int                            n_out = 0;
  int                            n_flushed = 0;
  int                            mismatches = 0;
  int                            other_errs = 0;

  divsqrt_top dut0 (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .flush_i     ( flush     ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .req_i       ( req       ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .resp_o      ( resp      ),
    .busy_o      ( busy      )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // --------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Largest root whose square fits, built top bit first with wide products
  function automatic logic [31:0] isqrt_ref(input logic [31:0] a);
    logic [31:0] r;
    logic [31:0] cand;
    logic [63:0] sq;
    r = '0;
    for (int k = W / 2 - 1; k >= 0; k--) begin
      cand = r | (32'd1 << k);
      sq   = {32'd0, cand} * {32'd0, cand};
      if (sq <= {32'd0, a}) begin
        r = cand;
      end
    end
    return r;
  endfunction

  function automatic divsqrt_resp_t ref_resp(input divsqrt_req_t r);
    divsqrt_resp_t e;
    e.tag       = r.tag;
    e.status.dz = 1'b0;
    if (r.op == OP_SQRT) begin
      e.result = isqrt_ref(r.a);
    end else if (r.b == '0) begin
      e.result    = '1;
      e.status.dz = 1'b1;
    end else begin
      e.result = r.a / r.b;
    end
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Drivers, called at 10 ns after a rising edge
  // --------------------------------------------------
  task automatic send_req(input divsqrt_req_t r);
    req      = r;
    in_valid = 1'b1;
    // Handshake settles before the falling edge
    do @(negedge clk); while (!in_ready);
    accept_cycle = cycle_cnt;
    @(posedge clk);
    exp_q.push_back(ref_resp(r));
    n_in++;
    #10;
    in_valid = 1'b0;
  endtask

  task automatic issue_one(input divsqrt_op_e op, input logic zero_b);
    divsqrt_req_t r;
    logic [31:0]  sha;
    logic [31:0]  shb;
    sha   = take_bits(5);
    r.a   = take_bits(W) >> sha;
    shb   = take_bits(5);
    r.b   = take_bits(W) >> shb;
    if (zero_b) begin
      r.b = '0;
    end
    r.op    = op;
    r.tag   = tag_cnt;
    tag_cnt = tag_cnt + 1'b1;
    send_req(r);
  endtask

  // Wait for the last pending result, then the unit must be idle
  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
    check_value("busy_o", busy, 1'b0);
    @(posedge clk);
    #10;
  endtask

  // Random back-pressure, drawn on the edge so it never meets the main draws
  // Ready in about one cycle of 16, so a stall often outlasts a core run
  // and the next result has to wait in the hold register
  initial begin : ready_driver
    logic nxt;
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      nxt = stall_en ? (take_bits(4) == 32'd0) : 1'b1;
      #10;
      out_ready = nxt;
    end
  end

  // Transfer happens on the next rising edge
  always @(negedge clk) begin : monitor
    divsqrt_resp_t e;
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("%0t ns: output transfer with no request pending", $time);
      end else begin
        e = exp_q.pop_front();
        check_value("resp_o.result", resp.result, e.result);
        check_value("resp_o.status.dz", resp.status.dz, e.status.dz);
        check_value("resp_o.tag", resp.tag, e.tag);
        n_out++;
        last_out_cycle = cycle_cnt;
      end
    end
  end

  initial begin : watchdog
    repeat (LIMIT) @(posedge clk);
    $display("Run did not finish within %0d cycles, DUT stopped responding", LIMIT);
    $display("tests failed");
    $finish;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : stimulus
    divsqrt_op_e op;
    rst_n    = 1'b0;
    flush    = 1'b0;
    in_valid = 1'b0;
    req      = '0;
    repeat (10) @(posedge clk);
    #10;
    rst_n = 1'b1;

    // Idle after reset
    @(negedge clk);
    check_value("out_valid_o", out_valid, 1'b0);
    check_value("busy_o", busy, 1'b0);
    @(posedge clk);
    #10;

    // Latency without back-pressure
    issue_one(OP_DIV, 1'b0);
    wait_drain();
    check_value("div latency", last_out_cycle - accept_cycle,
                `DIVSQRT_NUM_INP_REGS + W + `DIVSQRT_NUM_OUT_REGS + 1);
    issue_one(OP_SQRT, 1'b0);
    wait_drain();
    check_value("sqrt latency", last_out_cycle - accept_cycle,
                `DIVSQRT_NUM_INP_REGS + W / 2 + `DIVSQRT_NUM_OUT_REGS + 1);

    repeat (N_DIV) issue_one(OP_DIV, 1'b0);
    wait_drain();
    repeat (N_SQRT) issue_one(OP_SQRT, 1'b0);
    wait_drain();
    repeat (N_DZ) issue_one(OP_DIV, 1'b1);
    wait_drain();

    // Mixed ops under random stalls
    stall_en = 1'b1;
    repeat (N_BP) begin
      op = take_bits(1) ? OP_SQRT : OP_DIV;
      issue_one(op, 1'b0);
    end
    wait_drain();
    stall_en = 1'b0;
    repeat (2) @(posedge clk);
    #10;

    // Two divides in flight, then flush
    issue_one(OP_DIV, 1'b0);
    issue_one(OP_DIV, 1'b0);
    repeat (3) @(posedge clk);
    #10;
    flush = 1'b1;
    @(posedge clk);
    #10;
    flush     = 1'b0;
    n_flushed = n_flushed + exp_q.size();
    exp_q.delete();
    @(negedge clk);
    check_value("busy_o", busy, 1'b0);
    // Killed requests must never surface
    repeat (W + 10) @(posedge clk);
    #10;
    issue_one(OP_SQRT, 1'b0);
    wait_drain();

    check_value("result count", n_out, n_in - n_flushed);
    $display("%0d results checked, %0d mismatches, %0d other errors",
             n_out, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
verilog/divsqrt_pkg.sv
verilog/divsqrt_pipe_regs.sv
verilog/divsqrt_iter_core.sv
verilog/divsqrt_ctrl.sv
verilog/divsqrt_top.sv
sim/tb_divsqrt.sv

// File: verilog/divsqrt_ctrl.sv
// Control FSM between input pipeline and core, holds stalled results and returns the request tag
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_macros.svh"

module divsqrt_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  divsqrt_pkg::divsqrt_req_t     req_i,
  input  logic                          core_ready_i,
  input  logic                          core_done_i,
  input  logic [`DIVSQRT_WIDTH-1:0]     core_result_i,
  input  divsqrt_pkg::divsqrt_status_t  core_status_i,
  output logic                          div_start_o,
  output logic                          sqrt_start_o,
  output logic [`DIVSQRT_WIDTH-1:0]     core_a_o,
  output logic [`DIVSQRT_WIDTH-1:0]     core_b_o,
  output logic                          kill_o,
  output logic                          resp_valid_o,
  input  logic                          resp_ready_i,
  output divsqrt_pkg::divsqrt_resp_t    resp_o,
  output logic                          busy_o
);
  import divsqrt_pkg::*;

  divsqrt_state_e                state_q;
  divsqrt_state_e                state_d;
  // High in the cycle a request goes into the core
  logic                          op_start;
  logic                          hold_en;
  logic [`DIVSQRT_TAG_WIDTH-1:0] tag_q;
  logic [`DIVSQRT_WIDTH-1:0]     held_result_q;
  divsqrt_status_t               held_status_q;

  // --------------------------------------------------
  // Core start and kill
  // --------------------------------------------------
  assign op_start     = req_valid_i & req_ready_o & ~flush_i;
  assign div_start_o  = op_start & (req_i.op == OP_DIV);
  assign sqrt_start_o = op_start & (req_i.op == OP_SQRT);
  assign core_a_o     = req_i.a;
  assign core_b_o     = req_i.b;
  assign kill_o       = flush_i;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb begin : fsm_next
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    busy_o       = 1'b0;
    state_d      = state_q;

    unique case (state_q)
      IDLE: begin
        // Free for a new request
        req_ready_o = 1'b1;
        if (req_valid_i && core_ready_i) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        busy_o = 1'b1;
        if (core_done_i) begin
          resp_valid_o = 1'b1;
          if (resp_ready_i) begin
            // Result leaves now, next request may start in the same cycle
            state_d     = IDLE;
            req_ready_o = core_ready_i;
            if (req_valid_i && core_ready_i) begin
              state_d = BUSY;
            end
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        busy_o       = 1'b1;
        resp_valid_o = 1'b1;
        if (resp_ready_i) begin
          state_d = IDLE;
          if (req_valid_i && core_ready_i) begin
            req_ready_o = 1'b1;
            state_d     = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush wins over everything
    if (flush_i) begin
      busy_o       = 1'b0;
      resp_valid_o = 1'b0;
      state_d      = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : fsm_reg
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // Tag and hold registers
  // --------------------------------------------------
  // Core result is only valid for the done cycle
  assign hold_en = core_done_i & ~resp_ready_i;

  always_ff @(posedge clk_i) begin : payload_regs
    if (op_start) begin
      tag_q <= req_i.tag;
    end
    if (hold_en) begin
      held_result_q <= core_result_i;
      held_status_q <= core_status_i;
    end
  end

  // Held data has priority
  always_comb begin : out_select
    resp_o.tag = tag_q;
    if (state_q == HOLD) begin
      resp_o.result = held_result_q;
      resp_o.status = held_status_q;
    end else begin
      resp_o.result = core_result_i;
      resp_o.status = core_status_i;
    end
  end

  a_no_resp_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == IDLE) |-> !resp_valid_o)
    else $error("response valid while idle");

  // Core finishes only the operation this FSM started
  a_done_in_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_done_i |-> (state_q == BUSY))
    else $error("core done outside BUSY");

endmodule

`default_nettype wire

// File: verilog/divsqrt_iter_core.sv
// Iterative unsigned divider and integer square root, one result bit per cycle, pulse started
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_macros.svh"

module divsqrt_iter_core (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          div_start_i,
  input  logic                          sqrt_start_i,
  input  logic [`DIVSQRT_WIDTH-1:0]     operand_a_i,
  input  logic [`DIVSQRT_WIDTH-1:0]     operand_b_i,
  input  logic                          kill_i,
  output logic                          ready_o,
  output logic                          done_o,
  output logic [`DIVSQRT_WIDTH-1:0]     result_o,
  output divsqrt_pkg::divsqrt_status_t  status_o
);
  import divsqrt_pkg::*;

  localparam int unsigned Width    = `DIVSQRT_WIDTH;
  localparam int unsigned Half     = Width / 2;
  localparam int unsigned CntWidth = $clog2(Width + 1);

  // Control state
  logic                busy_q;
  logic                done_q;
  logic [CntWidth-1:0] cnt_q;
  divsqrt_op_e         mode_q;
  logic                start;
  // Dividend or radicand, shifted out at the top
  // Quotient bits shift in at the bottom
  logic [Width-1:0]    opa_q;
  logic [Width-1:0]    opb_q;
  logic [Width:0]      rem_q;
  logic [Half-1:0]     root_q;
  logic                dz_q;
  // One iteration step
  logic [Width:0]      div_rem;
  logic                div_ge;
  logic [Width:0]      sqrt_rem;
  logic [Width:0]      sqrt_trial;
  logic                sqrt_ge;
  logic [Width:0]      rem_d;
  logic [Width-1:0]    opa_d;
  logic [Half-1:0]     root_d;

  assign start = div_start_i | sqrt_start_i;

  // --------------------------------------------------
  // Shift-subtract step
  // --------------------------------------------------
  always_comb begin : iter_step
    // Divide brings down one dividend bit
    div_rem    = {rem_q[Width-1:0], opa_q[Width-1]};
    div_ge     = (div_rem >= {1'b0, opb_q});
    // Square root brings down one bit pair, trial is 4*root + 1
    sqrt_rem   = {rem_q[Width-2:0], opa_q[Width-1:Width-2]};
    sqrt_trial = {{(Half-1){1'b0}}, root_q, 2'b01};
    sqrt_ge    = (sqrt_rem >= sqrt_trial);
    root_d     = root_q;

    if (mode_q == OP_DIV) begin
      rem_d = div_ge ? (div_rem - {1'b0, opb_q}) : div_rem;
      opa_d = {opa_q[Width-2:0], div_ge};
    end else begin
      rem_d  = sqrt_ge ? (sqrt_rem - sqrt_trial) : sqrt_rem;
      opa_d  = {opa_q[Width-3:0], 2'b00};
      root_d = {root_q[Half-2:0], sqrt_ge};
    end
  end

  // --------------------------------------------------
  // Sequencing
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_regs
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
      mode_q <= OP_DIV;
    end else if (kill_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      // One bit per step, Width for divide and Width/2 for root
      cnt_q  <= div_start_i ? CntWidth'(Width) : CntWidth'(Half);
      mode_q <= div_start_i ? OP_DIV : OP_SQRT;
    end else if (busy_q) begin
      cnt_q  <= cnt_q - 1'b1;
      busy_q <= (cnt_q != CntWidth'(1));
      done_q <= (cnt_q == CntWidth'(1));
    end else begin
      done_q <= 1'b0;
    end
  end

  // b == 0 makes every step succeed, quotient ends up all ones
  always_ff @(posedge clk_i) begin : data_regs
    if (start) begin
      opa_q  <= operand_a_i;
      opb_q  <= operand_b_i;
      rem_q  <= '0;
      root_q <= '0;
      dz_q   <= div_start_i & (operand_b_i == '0);
    end else if (busy_q) begin
      opa_q  <= opa_d;
      rem_q  <= rem_d;
      root_q <= root_d;
    end
  end

  assign ready_o   = ~busy_q;
  assign done_o    = done_q;
  assign result_o  = (mode_q == OP_DIV) ? opa_q : {{(Width-Half){1'b0}}, root_q};
  assign status_o  = '{dz: dz_q};

  // Control may only start an idle core
  a_start_ready : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (div_start_i || sqrt_start_i) |-> ready_o)
    else $error("core started while busy");

endmodule

`default_nettype wire

// File: verilog/divsqrt_pipe_regs.sv
// Chain of valid/ready register stages with flush, instantiated for the input and output pipelines
`timescale 1ns/1ps
`default_nettype none

module divsqrt_pipe_regs #(
  parameter int unsigned NumRegs = 1,
  parameter type         data_t  = logic
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  flush_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  data_t in_data_i,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output data_t out_data_o,
  output logic  busy_o
);

  // Index i carries the item after i stages
  data_t            data [0:NumRegs];
  logic [0:NumRegs] valid;
  // Ready is combinational through every stage
  logic [0:NumRegs] ready;

  // Stage 0 is the upstream side
  assign data[0]    = in_data_i;
  assign valid[0]   = in_valid_i;
  assign in_ready_o = ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic  stage_valid_q;
    data_t stage_data_q;

    // Advance when the next stage takes our item or we only hold a bubble
    assign ready[i] = ready[i+1] | ~stage_valid_q;

    // Valid bit, cleared by flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
      if (!rst_n_i) begin
        stage_valid_q <= 1'b0;
      end else if (flush_i) begin
        stage_valid_q <= 1'b0;
      end else if (ready[i]) begin
        stage_valid_q <= valid[i];
      end
    end

    // Payload loads only with a real item
    always_ff @(posedge clk_i) begin : data_reg
      if (ready[i] && valid[i]) begin
        stage_data_q <= data[i];
      end
    end

    assign valid[i+1] = stage_valid_q;
    assign data[i+1]  = stage_data_q;
  end

  // Downstream ready enters at the last stage
  assign ready[NumRegs] = out_ready_i;
  assign out_valid_o    = valid[NumRegs];
  assign out_data_o     = data[NumRegs];

  // Any stage holding an item
  if (NumRegs > 0) begin : gen_busy
    assign busy_o = |valid[1:NumRegs];
  end else begin : gen_no_busy
    assign busy_o = 1'b0;
  end

  // Stalled output keeps its payload until taken
  a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> $stable(out_data_o))
    else $error("pipe output changed while stalled");

endmodule

`default_nettype wire

// File: verilog/divsqrt_pkg.sv
// Opcode, state and handshake payload types of the divide/sqrt unit, imported by its modules
`default_nettype none
`include "divsqrt_macros.svh"

package divsqrt_pkg;

  // --------------------------------------------------
  // Enumerations
  // --------------------------------------------------
  // Operation selected by a request
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divsqrt_op_e;

  // Control FSM states
  // IDLE waits for work, BUSY runs the core, HOLD keeps a stalled result
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    HOLD = 2'd2
  } divsqrt_state_e;

  // --------------------------------------------------
  // Payload structs
  // --------------------------------------------------
  // Exception flags of one result
  typedef struct packed {
    logic dz;
  } divsqrt_status_t;

  // Request as it enters the unit
  typedef struct packed {
    logic [`DIVSQRT_WIDTH-1:0]     a;
    logic [`DIVSQRT_WIDTH-1:0]     b;
    divsqrt_op_e                   op;
    logic [`DIVSQRT_TAG_WIDTH-1:0] tag;
  } divsqrt_req_t;

  // Response as it leaves the unit
  // Tag is returned unchanged from the request
  typedef struct packed {
    logic [`DIVSQRT_WIDTH-1:0]     result;
    divsqrt_status_t               status;
    logic [`DIVSQRT_TAG_WIDTH-1:0] tag;
  } divsqrt_resp_t;

endpackage

`default_nettype wire

// File: verilog/divsqrt_top.sv
// Top of the divide/sqrt unit with valid/ready request and response ports, for system integration
`timescale 1ns/1ps
`default_nettype none
`include "divsqrt_macros.svh"

module divsqrt_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        flush_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  divsqrt_pkg::divsqrt_req_t   req_i,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output divsqrt_pkg::divsqrt_resp_t  resp_o,
  output logic                        busy_o
);
  import divsqrt_pkg::*;

  // Input pipeline to control
  divsqrt_req_t              req_q;
  logic                      req_valid;
  logic                      req_ready;
  logic                      inp_busy;
  // Control to core
  logic                      div_start;
  logic                      sqrt_start;
  logic [`DIVSQRT_WIDTH-1:0] core_a;
  logic [`DIVSQRT_WIDTH-1:0] core_b;
  logic                      core_kill;
  logic                      core_ready;
  logic                      core_done;
  logic [`DIVSQRT_WIDTH-1:0] core_result;
  divsqrt_status_t           core_status;
  // Control to output pipeline
  divsqrt_resp_t             resp_d;
  logic                      resp_valid;
  logic                      resp_ready;
  logic                      ctrl_busy;
  logic                      out_busy;

  // --------------------------------------------------
  // Input pipeline
  // --------------------------------------------------
  divsqrt_pipe_regs #(
    .NumRegs ( `DIVSQRT_NUM_INP_REGS ),
    .data_t  ( divsqrt_req_t         )
  ) i_inp_pipe (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .flush_i     ( flush_i    ),
    .in_valid_i  ( in_valid_i ),
    .in_ready_o  ( in_ready_o ),
    .in_data_i   ( req_i      ),
    .out_valid_o ( req_valid  ),
    .out_ready_i ( req_ready  ),
    .out_data_o  ( req_q      ),
    .busy_o      ( inp_busy   )
  );

  // --------------------------------------------------
  // Control and core
  // --------------------------------------------------
  divsqrt_ctrl i_ctrl (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .flush_i       ( flush_i     ),
    .req_valid_i   ( req_valid   ),
    .req_ready_o   ( req_ready   ),
    .req_i         ( req_q       ),
    .core_ready_i  ( core_ready  ),
    .core_done_i   ( core_done   ),
    .core_result_i ( core_result ),
    .core_status_i ( core_status ),
    .div_start_o   ( div_start   ),
    .sqrt_start_o  ( sqrt_start  ),
    .core_a_o      ( core_a      ),
    .core_b_o      ( core_b      ),
    .kill_o        ( core_kill   ),
    .resp_valid_o  ( resp_valid  ),
    .resp_ready_i  ( resp_ready  ),
    .resp_o        ( resp_d      ),
    .busy_o        ( ctrl_busy   )
  );

  divsqrt_iter_core i_core (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .div_start_i  ( div_start   ),
    .sqrt_start_i ( sqrt_start  ),
    .operand_a_i  ( core_a      ),
    .operand_b_i  ( core_b      ),
    .kill_i       ( core_kill   ),
    .ready_o      ( core_ready  ),
    .done_o       ( core_done   ),
    .result_o     ( core_result ),
    .status_o     ( core_status )
  );

  // --------------------------------------------------
  // Output pipeline
  // --------------------------------------------------
  divsqrt_pipe_regs #(
    .NumRegs ( `DIVSQRT_NUM_OUT_REGS ),
    .data_t  ( divsqrt_resp_t        )
  ) i_out_pipe (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( resp_valid  ),
    .in_ready_o  ( resp_ready  ),
    .in_data_i   ( resp_d      ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_data_o  ( resp_o      ),
    .busy_o      ( out_busy    )
  );

  // Anything in flight anywhere
  assign busy_o = inp_busy | ctrl_busy | out_busy;

endmodule

`default_nettype wire
